// File: flist.f
src/kvdb_pkg.sv
src/kvdb_regs.sv
src/kvdb_cmd_fsm.sv
src/kvdb_watchdog.sv
src/kvdb_stash.sv
src/kvdb_top.sv
verif/kvdb_sva.sv
verif/kvdb_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the kvdb testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module kvdb_tb -f flist.f -o kvdb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/kvdb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit $status
fi

exit 0

// File: verif/kvdb_tb.sv
// Testbench for kvdb_top; stops at the first mismatch and needs a simulator with timing support
module kvdb_tb;
    import kvdb_pkg::*;

    logic      clk;
    logic      srst;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;

    // Reference model of the stash contents
    value_t      model [key_t];
    key_t        key_pool [12];
    logic [31:0] rnd;

    kvdb_top dut_i (
        .clk       (clk),
        .srst      (srst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    always #20 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
        end
    endtask

    // Bus tasks start and end on a falling edge
    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge clk);
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic issue(input logic [2:0] code, input key_t k, input value_t v);
        reg_write(ADDR_KEY, reg_data_t'(k));
        reg_write(ADDR_SET_VALUE, v);
        reg_write(ADDR_COMMAND, reg_data_t'(code));
    endtask

    // Gathers flags over reads until some flag was seen and the code is back at READY
    task automatic poll_status(output reg_data_t st);
        reg_data_t rd;
        reg_data_t flags;
        logic      fin;
        int        n;
        flags = '0;
        fin   = 1'b0;
        n     = 0;
        while (!fin) begin
            if (n == 40) abort_run("STATUS poll timed out before the command finished");
            reg_read(ADDR_STATUS, rd);
            flags = flags | (rd & 32'h0000_0700);
            fin   = (flags != '0) && (rd[1:0] == 2'(CODE_READY));
            n++;
        end
        st = flags | {30'd0, rd[1:0]};
    endtask

    task automatic run_cmd(input logic [2:0] code, input key_t k, input value_t v,
                           output reg_data_t st);
        issue(code, k, v);
        poll_status(st);
    endtask

    // Watches the done flag inside the DUT without any STATUS read
    task automatic wait_done();
        int n;
        n = 0;
        while (!dut_i.status.done) begin
            if (n == 100) abort_run("done flag never rose after the command");
            @(negedge clk);
            n++;
        end
    endtask

    // Runs one command with the watchdog off and checks it against the model
    task automatic exec(input logic [2:0] code, input key_t k, input value_t v);
        reg_data_t st;
        reg_data_t rd;
        logic      hit;
        logic      exp_err;
        value_t    exp_val;
        hit     = model.exists(k);
        exp_err = (code == CMD_SET) && !hit && (model.num() >= DB_DEPTH);
        exp_val = '0;
        if (hit) exp_val = model[k];
        run_cmd(code, k, v, st);
        check("STATUS.done", 32'(st[8]), 32'(!exp_err));
        check("STATUS.error", 32'(st[9]), 32'(exp_err));
        check("STATUS.timeout", 32'(st[10]), 32'd0);
        if (code == CMD_GET || code == CMD_UNSET) begin
            reg_read(ADDR_GET_VALID, rd);
            check("GET_VALID", rd, 32'(hit));
        end
        if (code == CMD_GET) begin
            reg_read(ADDR_GET_VALUE, rd);
            check("GET_VALUE", rd, exp_val);
        end
        if (code == CMD_SET && !exp_err) model[k] = v;
        if (code == CMD_UNSET && hit) model.delete(k);
        if (code == CMD_CLEAR) model.delete();
        reg_read(ADDR_FILL, rd);
        check("FILL", rd, 32'(model.num()));
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        reg_data_t   rd;
        reg_data_t   st;
        logic [3:0]  pidx;
        logic [1:0]  sel;
        int          miss;
        clk       = 1'b0;
        srst      = 1'b1;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        rnd       = 32'd13372;
        for (int i = 0; i < 12; i++) begin
            key_pool[i] = key_t'(4096 + i * 273);
        end
        repeat (3) @(negedge clk);
        srst = 1'b0;
        @(negedge clk);

        // Idle state after reset
        reg_read(ADDR_STATUS, rd);
        check("STATUS", rd, 32'h0000_0001);
        reg_read(ADDR_FILL, rd);
        check("FILL", rd, 32'd0);
        reg_read(ADDR_INFO, rd);
        check("INFO.depth", 32'(rd[7:0]), 32'd8);
        check("INFO.key_width", 32'(rd[15:8]), 32'd16);
        check("INFO.value_width", 32'(rd[23:16]), 32'd32);

        // Random GET, SET and UNSET
        // SET is drawn twice as often
        for (int i = 0; i < 300; i++) begin
            rnd  = xorshift(rnd);
            pidx = 4'(rnd % 32'd12);
            sel  = rnd[9:8];
            rnd  = xorshift(rnd);
            case (sel)
                2'd0:    exec(CMD_GET, key_pool[pidx], '0);
                2'd3:    exec(CMD_UNSET, key_pool[pidx], '0);
                default: exec(CMD_SET, key_pool[pidx], rnd);
            endcase
        end

        // A full table refuses a new key and updates an existing one
        for (int i = 0; i < 12; i++) begin
            rnd = xorshift(rnd);
            if (model.num() < DB_DEPTH && !model.exists(key_pool[i])) begin
                exec(CMD_SET, key_pool[i], rnd);
            end
        end
        miss = 0;
        while (model.exists(key_pool[miss])) miss++;
        exec(CMD_SET, key_pool[miss], 32'hdead_beef);
        for (int i = 0; i < 12; i++) begin
            exec(CMD_GET, key_pool[i], '0);
        end
        miss = 0;
        while (!model.exists(key_pool[miss])) miss++;
        exec(CMD_SET, key_pool[miss], 32'h1234_5678);

        // CLEAR leaves every pool key missing
        exec(CMD_CLEAR, '0, '0);
        for (int i = 0; i < 12; i++) begin
            exec(CMD_GET, key_pool[i], '0);
        end

        // Done is cleared by the read that returned it
        exec(CMD_SET, key_pool[0], 32'h0a0a_0a0a);
        reg_read(ADDR_STATUS, rd);
        check("STATUS", rd, 32'h0000_0001);

        // A stale done goes away with the next command
        issue(CMD_SET, key_pool[1], 32'h0b0b_0b0b);
        model[key_pool[1]] = 32'h0b0b_0b0b;
        wait_done();
        issue(CMD_GET, key_pool[1], '0);
        reg_read(ADDR_STATUS, rd);
        check("STATUS.done", 32'(rd[8]), 32'd0);
        poll_status(st);
        check("STATUS.done", 32'(st[8]), 32'd1);
        reg_read(ADDR_GET_VALUE, rd);
        check("GET_VALUE", rd, 32'h0b0b_0b0b);

        // ------------------------------
        // Watchdog
        // ------------------------------
        exec(CMD_GET, key_pool[0], '0);
        reg_write(ADDR_TIMEOUT, 32'd1);
        run_cmd(CMD_SET, key_pool[2], 32'h0c0c_0c0c, st);
        check("STATUS.flags", st & 32'h0000_0700, 32'h0000_0400);
        model[key_pool[2]] = 32'h0c0c_0c0c;
        reg_read(ADDR_FILL, rd);
        check("FILL", rd, 32'(model.num()));
        run_cmd(CMD_GET, key_pool[2], '0, st);
        check("STATUS.flags", st & 32'h0000_0700, 32'h0000_0400);
        // Still the value of the last completed GET
        reg_read(ADDR_GET_VALUE, rd);
        check("GET_VALUE", rd, model[key_pool[0]]);
        reg_write(ADDR_TIMEOUT, 32'd0);
        exec(CMD_GET, key_pool[2], '0);

        // Unknown code runs as NOP
        exec(3'd7, key_pool[3], 32'h0d0d_0d0d);
        exec(CMD_GET, key_pool[3], '0);

        $display("Everything OK");
        $finish;
    end

endmodule : kvdb_tb

// File: verif/kvdb_sva.sv
// Handshake checks bound into kvdb_cmd_fsm; state values follow the controller's enum coding
module kvdb_sva (
    input logic       clk,
    input logic       srst,
    input logic       req,
    input logic       rdy,
    input logic       ack,
    input logic       res_v,
    input logic [2:0] state
);

    // Request holds under back-pressure
    req_hold: assert property (@(posedge clk) disable iff (srst)
        req && !rdy |=> req)
        else $error("req dropped before rdy");

    no_x_after_reset: assert property (@(posedge clk)
        !srst |-> !$isunknown({req, res_v, state}))
        else $error("controller outputs unknown after reset");

    // BUSY, TIMEOUT and DRAIN are coded 3, 6 and 7
    ack_in_wait: assert property (@(posedge clk) disable iff (srst)
        ack |-> (state == 3'd3 || state == 3'd6 || state == 3'd7))
        else $error("ack outside a waiting state");

endmodule : kvdb_sva

bind kvdb_cmd_fsm kvdb_sva sva_i (
    .clk   (clk),
    .srst  (srst),
    .req   (req),
    .rdy   (rdy),
    .ack   (ack),
    .res_v (res_v),
    .state (state)
);

// File: src/kvdb_top.sv
// Database top level; register strobes only, no bus adapter and no clock crossing
module kvdb_top (
    input  logic                clk,
    input  logic                srst,
    input  logic                reg_wr,
    input  logic                reg_rd,
    input  kvdb_pkg::reg_addr_t reg_addr,
    input  kvdb_pkg::reg_data_t reg_wdata,
    output kvdb_pkg::reg_data_t reg_rdata
);
    import kvdb_pkg::*;

    logic     cmd_evt;
    logic     status_rd;
    db_req_t  cmd_req;
    status_t  status;
    logic     res_v;
    db_resp_t res;
    fill_t    fill;
    limit_t   limit;

    // Controller to stash
    db_req_t  db_req;
    logic     req;
    logic     rdy;
    logic     ack;
    db_resp_t db_resp;

    logic     run;
    logic     expired;

    kvdb_regs regs_i (
        .clk       (clk),
        .srst      (srst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cmd_evt   (cmd_evt),
        .status_rd (status_rd),
        .cmd_req   (cmd_req),
        .status    (status),
        .res_v     (res_v),
        .res       (res),
        .fill      (fill),
        .limit     (limit)
    );

    kvdb_cmd_fsm cmd_fsm_i (
        .clk       (clk),
        .srst      (srst),
        .cmd_evt   (cmd_evt),
        .cmd_req   (cmd_req),
        .status_rd (status_rd),
        .db_req    (db_req),
        .req       (req),
        .rdy       (rdy),
        .ack       (ack),
        .db_resp   (db_resp),
        .run       (run),
        .expired   (expired),
        .status    (status),
        .res_v     (res_v),
        .res       (res)
    );

    kvdb_watchdog watchdog_i (
        .clk     (clk),
        .srst    (srst),
        .run     (run),
        .limit   (limit),
        .expired (expired)
    );

    kvdb_stash stash_i (
        .clk     (clk),
        .srst    (srst),
        .req     (req),
        .db_req  (db_req),
        .rdy     (rdy),
        .ack     (ack),
        .db_resp (db_resp),
        .fill    (fill)
    );

endmodule : kvdb_top

// File: src/kvdb_stash.sv
// Eight-entry stash; one request at a time, ack comes 3 to DB_DEPTH+2 cycles after acceptance
module kvdb_stash (
    input  logic               clk,
    input  logic               srst,
    input  logic               req,
    input  kvdb_pkg::db_req_t  db_req,
    output logic               rdy,
    output logic               ack,
    output kvdb_pkg::db_resp_t db_resp,
    output kvdb_pkg::fill_t    fill
);
    import kvdb_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_SCAN  = 2'd1,
        S_WRITE = 2'd2,
        S_ACK   = 2'd3
    } stash_state_t;

    stash_state_t                state;
    logic [DB_DEPTH-1:0]         valid;
    key_t                        keys   [DB_DEPTH];
    value_t                      values [DB_DEPTH];
    db_req_t                     cur;
    db_resp_t                    resp_q;
    logic [$clog2(DB_DEPTH)-1:0] idx;
    logic [$clog2(DB_DEPTH)-1:0] hit_idx;
    logic [$clog2(DB_DEPTH)-1:0] free_idx;
    logic                        hit;
    logic                        free_found;
    logic                        match;
    logic                        last;
    logic                        full;

    // Entry under the scan pointer
    assign match = valid[idx] && (keys[idx] == cur.key);
    assign last  = (int'(idx) == DB_DEPTH - 1);

    assign rdy     = (state == S_IDLE);
    assign ack     = (state == S_ACK);
    assign db_resp = resp_q;

    // ------------------------------
    // Occupancy
    // ------------------------------
    always_comb begin
        fill = '0;
        for (int i = 0; i < DB_DEPTH; i++) begin
            fill = fill + fill_t'(valid[i]);
        end
    end

    assign full = (fill == fill_t'(DB_DEPTH));

    // ------------------------------
    // Control and valid bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= S_IDLE;
            valid <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (req) state <= S_SCAN;
                end
                S_SCAN: begin
                    if (cur.command == CMD_CLEAR) begin
                        // One entry per cycle, no write stage
                        valid[idx] <= 1'b0;
                        if (last) state <= S_ACK;
                    end else if (match || last) begin
                        state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    state <= S_ACK;
                    if (cur.command == CMD_SET && !hit && !full) begin
                        valid[free_idx] <= 1'b1;
                    end
                    if (cur.command == CMD_UNSET && hit) begin
                        valid[hit_idx] <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ------------------------------
    // Search and storage
    // ------------------------------
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (req) begin
                    cur        <= db_req;
                    idx        <= '0;
                    hit        <= 1'b0;
                    free_found <= 1'b0;
                    resp_q     <= '{status: ST_OK, get_valid: 1'b0, get_value: '0};
                end
            end
            S_SCAN: begin
                idx <= idx + 1'b1;
                if (match) begin
                    hit     <= 1'b1;
                    hit_idx <= idx;
                end
                // First free slot only
                if (!valid[idx] && !free_found) begin
                    free_found <= 1'b1;
                    free_idx   <= idx;
                end
            end
            S_WRITE: begin
                case (cur.command)
                    CMD_GET: begin
                        resp_q.get_valid <= hit;
                        if (hit) resp_q.get_value <= values[hit_idx];
                    end
                    CMD_SET: begin
                        if (hit) begin
                            values[hit_idx] <= cur.set_value;
                        end else if (!full) begin
                            keys[free_idx]   <= cur.key;
                            values[free_idx] <= cur.set_value;
                        end else begin
                            resp_q.status <= ST_ERROR;
                        end
                    end
                    CMD_UNSET: resp_q.get_valid <= hit;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule : kvdb_stash

// File: src/kvdb_watchdog.sv
// Request watchdog; expired fires in the limit-th cycle of run, a limit of zero never fires
module kvdb_watchdog (
    input  logic             clk,
    input  logic             srst,
    input  logic             run,
    input  kvdb_pkg::limit_t limit,
    output logic             expired
);
    import kvdb_pkg::*;

    limit_t cnt;

    // Counts cycles of run and stops at the limit
    always_ff @(posedge clk) begin
        if (srst || !run) begin
            cnt <= '0;
        end else if (limit != '0 && cnt != limit) begin
            cnt <= cnt + 1'b1;
        end
    end

    // Single pulse since the counter parks on the limit
    assign expired = run && (limit != '0) && (limit_t'(cnt + 1'b1) == limit);

endmodule : kvdb_watchdog

// File: src/kvdb_cmd_fsm.sv
// Transaction controller; commands are only taken in IDLE, and DRAIN after a timeout reports code BUSY
module kvdb_cmd_fsm (
    input  logic               clk,
    input  logic               srst,
    input  logic               cmd_evt,
    input  kvdb_pkg::db_req_t  cmd_req,
    input  logic               status_rd,
    output kvdb_pkg::db_req_t  db_req,
    output logic               req,
    input  logic               rdy,
    input  logic               ack,
    input  kvdb_pkg::db_resp_t db_resp,
    output logic               run,
    input  logic               expired,
    output kvdb_pkg::status_t  status,
    output logic               res_v,
    output kvdb_pkg::db_resp_t res
);
    import kvdb_pkg::*;

    typedef enum logic [2:0] {
        RESET   = 3'd0,
        IDLE    = 3'd1,
        REQ     = 3'd2,
        BUSY    = 3'd3,
        DONE    = 3'd4,
        ERROR   = 3'd5,
        TIMEOUT = 3'd6,
        DRAIN   = 3'd7
    } state_t;

    state_t   state;
    state_t   nxt_state;
    logic     accept;
    logic     done_q;
    logic     error_q;
    logic     timeout_q;
    db_resp_t resp_q;

    assign accept = cmd_evt && (state == IDLE);

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            RESET: nxt_state = IDLE;
            IDLE: begin
                if (accept) nxt_state = REQ;
            end
            REQ: begin
                if (rdy) nxt_state = BUSY;
            end
            BUSY: begin
                // A result arriving with the expiry still counts
                if (ack) begin
                    nxt_state = (db_resp.status == ST_ERROR) ? ERROR : DONE;
                end else if (expired) begin
                    nxt_state = TIMEOUT;
                end
            end
            TIMEOUT: nxt_state = ack ? IDLE : DRAIN;
            DRAIN: begin
                // Late result is dropped here
                if (ack) nxt_state = IDLE;
            end
            default: nxt_state = IDLE;
        endcase
    end

    assign req   = (state == REQ);
    assign run   = (state == BUSY);
    assign res_v = (state == DONE) || (state == ERROR);
    assign res   = resp_q;

    // ------------------------------
    // Request and result payload
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            db_req <= cmd_req;
        end
        if (state == BUSY && ack) begin
            resp_q <= db_resp;
        end
    end

    // ------------------------------
    // Sticky flags
    // ------------------------------
    // Set wins over clear; a read only clears what it returned
    always_ff @(posedge clk) begin
        if (srst) begin
            done_q    <= 1'b0;
            error_q   <= 1'b0;
            timeout_q <= 1'b0;
        end else begin
            done_q    <= (nxt_state == DONE) || (done_q && !(accept || status_rd));
            error_q   <= (nxt_state == ERROR) || (error_q && !(accept || status_rd));
            timeout_q <= (nxt_state == TIMEOUT) || (timeout_q && !(accept || status_rd));
        end
    end

    always_comb begin
        case (state)
            RESET:                    status.code = CODE_RESET;
            REQ, BUSY, TIMEOUT, DRAIN: status.code = CODE_BUSY;
            default:                  status.code = CODE_READY;
        endcase
        status.done    = done_q;
        status.error   = error_q;
        status.timeout = timeout_q;
    end

endmodule : kvdb_cmd_fsm

// File: src/kvdb_regs.sv
// Register file with strobe access; read data appears one cycle after reg_rd and unknown codes run as NOP
module kvdb_regs (
    input  logic                clk,
    input  logic                srst,
    input  logic                reg_wr,
    input  logic                reg_rd,
    input  kvdb_pkg::reg_addr_t reg_addr,
    input  kvdb_pkg::reg_data_t reg_wdata,
    output kvdb_pkg::reg_data_t reg_rdata,
    output logic                cmd_evt,
    output logic                status_rd,
    output kvdb_pkg::db_req_t   cmd_req,
    input  kvdb_pkg::status_t   status,
    input  logic                res_v,
    input  kvdb_pkg::db_resp_t  res,
    input  kvdb_pkg::fill_t     fill,
    output kvdb_pkg::limit_t    limit
);
    import kvdb_pkg::*;

    // Register code to command, anything outside 0..4 is a NOP
    function automatic command_t to_command(input reg_data_t code);
        case (code)
            32'd1:   return CMD_GET;
            32'd2:   return CMD_SET;
            32'd3:   return CMD_UNSET;
            32'd4:   return CMD_CLEAR;
            default: return CMD_NOP;
        endcase
    endfunction

    command_t  command_q;
    key_t      key_q;
    value_t    set_value_q;
    limit_t    limit_q;
    logic      get_valid_q;
    value_t    get_value_q;
    reg_data_t rd_data;

    assign cmd_evt   = reg_wr && (reg_addr == ADDR_COMMAND);
    assign status_rd = reg_rd && (reg_addr == ADDR_STATUS);
    assign limit     = limit_q;

    // The command word is taken straight from the bus in the write cycle
    assign cmd_req.command   = cmd_evt ? to_command(reg_wdata) : command_q;
    assign cmd_req.key       = key_q;
    assign cmd_req.set_value = set_value_q;

    // ------------------------------
    // Writable registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            command_q   <= CMD_NOP;
            limit_q     <= '0;
            get_valid_q <= 1'b0;
        end else begin
            if (cmd_evt) begin
                command_q <= to_command(reg_wdata);
            end
            if (reg_wr && reg_addr == ADDR_TIMEOUT) begin
                limit_q <= limit_t'(reg_wdata);
            end
            if (res_v) begin
                get_valid_q <= res.get_valid;
            end
        end
    end

    // Key, value and result payload
    always_ff @(posedge clk) begin
        if (reg_wr && reg_addr == ADDR_KEY) begin
            key_q <= key_t'(reg_wdata);
        end
        if (reg_wr && reg_addr == ADDR_SET_VALUE) begin
            set_value_q <= value_t'(reg_wdata);
        end
        if (res_v) begin
            get_value_q <= res.get_value;
        end
    end

    // ------------------------------
    // Read path
    // ------------------------------
    always_comb begin
        rd_data = '0;
        case (reg_addr)
            ADDR_COMMAND:   rd_data = reg_data_t'(command_q);
            ADDR_KEY:       rd_data = reg_data_t'(key_q);
            ADDR_SET_VALUE: rd_data = reg_data_t'(set_value_q);
            ADDR_STATUS: begin
                rd_data[1:0] = status.code;
                rd_data[8]   = status.done;
                rd_data[9]   = status.error;
                rd_data[10]  = status.timeout;
            end
            ADDR_GET_VALID: rd_data = reg_data_t'(get_valid_q);
            ADDR_GET_VALUE: rd_data = reg_data_t'(get_value_q);
            ADDR_FILL:      rd_data = reg_data_t'(fill);
            ADDR_TIMEOUT:   rd_data = reg_data_t'(limit_q);
            ADDR_INFO:      rd_data = {8'd0, 8'(VALUE_W), 8'(KEY_W), 8'(DB_DEPTH)};
            default:        rd_data = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_data;
        end
    end

endmodule : kvdb_regs

// File: src/kvdb_pkg.sv
// Shared types for the key-value database; key and value widths are fixed, depth is 8 entries
package kvdb_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int KEY_W    = 16;
    localparam int VALUE_W  = 32;
    localparam int DB_DEPTH = 8;

    typedef logic [KEY_W-1:0]                  key_t;
    typedef logic [VALUE_W-1:0]                value_t;
    typedef logic [3:0]                        reg_addr_t;
    typedef logic [31:0]                       reg_data_t;
    typedef logic [$clog2(DB_DEPTH+1)-1:0]     fill_t;
    // Zero disables the watchdog
    typedef logic [7:0]                        limit_t;

    // ------------------------------
    // Encodings
    // ------------------------------
    typedef enum logic [2:0] {
        CMD_NOP   = 3'd0,
        CMD_GET   = 3'd1,
        CMD_SET   = 3'd2,
        CMD_UNSET = 3'd3,
        CMD_CLEAR = 3'd4
    } command_t;

    typedef enum logic [1:0] {
        ST_OK    = 2'd0,
        ST_ERROR = 2'd1
    } db_status_t;

    typedef enum logic [1:0] {
        CODE_RESET = 2'd0,
        CODE_READY = 2'd1,
        CODE_BUSY  = 2'd2
    } status_code_t;

    // Register word addresses
    localparam reg_addr_t ADDR_COMMAND   = 4'd0;
    localparam reg_addr_t ADDR_KEY       = 4'd1;
    localparam reg_addr_t ADDR_SET_VALUE = 4'd2;
    localparam reg_addr_t ADDR_STATUS    = 4'd3;
    localparam reg_addr_t ADDR_GET_VALID = 4'd4;
    localparam reg_addr_t ADDR_GET_VALUE = 4'd5;
    localparam reg_addr_t ADDR_FILL      = 4'd6;
    localparam reg_addr_t ADDR_TIMEOUT   = 4'd7;
    localparam reg_addr_t ADDR_INFO      = 4'd8;

    // ------------------------------
    // Bundles
    // ------------------------------
    typedef struct packed {
        command_t command;
        key_t     key;
        value_t   set_value;
    } db_req_t;

    typedef struct packed {
        db_status_t status;
        logic       get_valid;
        value_t     get_value;
    } db_resp_t;

    // Mapped into STATUS bits 1:0, 8, 9 and 10
    typedef struct packed {
        status_code_t code;
        logic         done;
        logic         error;
        logic         timeout;
    } status_t;

endpackage : kvdb_pkg
